// File: Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --timing -Wno-fatal -f verilog.f --top-module tb_adc_input -Mdir obj_dir
	./obj_dir/Vtb_adc_input | tee sim.log
	grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log

// File: rtl/adc_in_pkg.sv
/*
  adc input front end shared definitions
  lane widths, lane and word types, frame pattern and parameter defaults
*/
`default_nettype none

package adc_in_pkg;

  localparam int CHANNELS    = 8;   // sample channels
  localparam int LANES       = 9;   // channels plus frame lane
  localparam int LANE_BITS   = 10;  // bits per deserialized lane
  localparam int SAMPLE_BITS = 16;  // output sample width

  typedef logic [LANE_BITS-1:0]         lane_t;      // one lane value
  typedef logic [SAMPLE_BITS-1:0]       sample_t;    // zero-extended sample
  typedef logic [2:0]                   chan_sel_t;  // channel index
  typedef logic [LANES*LANE_BITS-1:0]   raw_word_t;  // deserializer word, 90 bits
  typedef lane_t [CHANNELS-1:0]         lanes_t;     // all sample channels, 80 bits

  // frame lane in word alignment, high seven bits set
  localparam lane_t FRAME_PATTERN = 10'h3F8;

  // defaults for the module parameters, overridden from the top
  localparam int DEF_CAPTURE_AW    = 11;    // 2k word capture memory
  localparam int DEF_PIXEL_SIZE    = 2048;  // beats per packet
  localparam int DEF_CREDIT_MAX    = 4;     // credits held after reset
  localparam int DEF_STREAM_DEPTH  = 8;     // sample fifo entries
  localparam int DEF_SETTLE_CYCLES = 4;     // wait after each bitslip

endpackage

`default_nettype wire

// File: rtl/adc_input_top.sv
/*
  adc input front end top
  lane re-order, frame alignment, debug capture and the credit based stream
*/
`timescale 1ns/1ps
`default_nettype none

module adc_input_top
  import adc_in_pkg::*;
#(
  parameter int CAPTURE_AW    = DEF_CAPTURE_AW,
  parameter int PIXEL_SIZE    = DEF_PIXEL_SIZE,
  parameter int CREDIT_MAX    = DEF_CREDIT_MAX,
  parameter int STREAM_DEPTH  = DEF_STREAM_DEPTH,
  parameter int SETTLE_CYCLES = DEF_SETTLE_CYCLES
) (
  input  wire logic                               clk_adc,
  input  wire logic                               rst_adc_n,
  input  wire raw_word_t                          data_in,        // from the deserializer
  output logic                                    bitslip,        // to the deserializer
  output logic                                    locked,
  input  wire logic                               capture_start,
  input  wire chan_sel_t                          capture_sel,
  output logic                                    capture_busy,
  input  wire logic      [CAPTURE_AW-1:0]         rd_addr,        // debug readback
  output lane_t                                   rd_data,
  input  wire logic                               in_pixel,
  input  wire logic                               credit_return,
  output logic           [CHANNELS*SAMPLE_BITS-1:0] out_data,
  output logic                                    out_valid,
  output logic                                    out_last,
  output logic                                    overflow
);

  lanes_t                chan_lanes;
  lane_t                 frame_lane;
  logic                  addr_clear, addr_step, addr_last, wr_en;
  logic [CAPTURE_AW-1:0] wr_addr;

  lane_reorder lane_reorder_i (
    .clk_adc, .rst_adc_n, .data_in, .chan_lanes, .frame_lane
  );

  frame_align #(.SETTLE_CYCLES(SETTLE_CYCLES)) frame_align_i (
    .clk_adc, .rst_adc_n, .frame_lane, .bitslip, .locked
  );

  capture_fsm capture_fsm_i (
    .clk_adc, .rst_adc_n, .capture_start, .addr_last,
    .capture_busy, .addr_clear, .addr_step, .wr_en
  );

  capture_counter #(.CAPTURE_AW(CAPTURE_AW)) capture_counter_i (
    .clk_adc, .rst_adc_n, .addr_clear, .addr_step, .wr_addr, .addr_last
  );

  capture_mem #(.CAPTURE_AW(CAPTURE_AW)) capture_mem_i (
    .clk_adc, .chan_lanes, .capture_sel, .wr_en, .wr_addr, .rd_addr, .rd_data
  );

  stream_out #(
    .STREAM_DEPTH (STREAM_DEPTH),
    .CREDIT_MAX   (CREDIT_MAX),
    .PIXEL_SIZE   (PIXEL_SIZE)
  ) stream_out_i (
    .clk_adc, .rst_adc_n, .chan_lanes, .in_pixel, .locked, .credit_return,
    .out_data, .out_valid, .out_last, .overflow
  );

endmodule

`default_nettype wire

// File: rtl/capture_counter.sv
/*
  capture address counter
  write address for the debug memory, flags the final word of a run
*/
`timescale 1ns/1ps
`default_nettype none

module capture_counter
  import adc_in_pkg::*;
#(
  parameter int CAPTURE_AW = DEF_CAPTURE_AW
) (
  input  wire logic                  clk_adc,
  input  wire logic                  rst_adc_n,
  input  wire logic                  addr_clear,  // back to word 0
  input  wire logic                  addr_step,   // advance one word
  output logic      [CAPTURE_AW-1:0] wr_addr,
  output logic                       addr_last    // at the top address
);

  always_ff @(posedge clk_adc or negedge rst_adc_n) begin
    if (!rst_adc_n) begin
      wr_addr <= '0;
    end else if (addr_clear) begin
      wr_addr <= '0;
    end else if (addr_step) begin
      wr_addr <= wr_addr + 1'b1;  // wraps after the last word, fsm has stopped by then
    end
  end

  assign addr_last = &wr_addr;

endmodule

`default_nettype wire

// File: rtl/capture_fsm.sv
/*
  debug capture control
  idle/run FSM that steps the capture address and enables memory writes
*/
`timescale 1ns/1ps
`default_nettype none

module capture_fsm (
  input  wire logic clk_adc,
  input  wire logic rst_adc_n,
  input  wire logic capture_start,  // one cycle start or restart
  input  wire logic addr_last,      // write address is at its top
  output logic      capture_busy,
  output logic      addr_clear,
  output logic      addr_step,
  output logic      wr_en
);

  typedef enum logic {ST_IDLE, ST_RUN} state_t;

  state_t state;

  always_ff @(posedge clk_adc or negedge rst_adc_n) begin
    if (!rst_adc_n) begin
      state <= ST_IDLE;
    end else if (capture_start) begin
      state <= ST_RUN;                  // restart also lands here
    end else if (state == ST_RUN && addr_last) begin
      state <= ST_IDLE;                 // last word written this cycle
    end
  end

  assign capture_busy = (state == ST_RUN);
  assign addr_clear   = capture_start;                      // start from word 0
  assign addr_step    = (state == ST_RUN) && !capture_start;
  assign wr_en        = (state == ST_RUN);                  // one word per run cycle

endmodule

`default_nettype wire

// File: rtl/capture_mem.sv
/*
  debug capture memory
  registers the selected channel, writes it under wr_en, synchronous readback
*/
`timescale 1ns/1ps
`default_nettype none

module capture_mem
  import adc_in_pkg::*;
#(
  parameter int CAPTURE_AW = DEF_CAPTURE_AW
) (
  input  wire logic                       clk_adc,
  input  wire lanes_t                     chan_lanes,
  input  wire chan_sel_t                  capture_sel,  // stable during a run
  input  wire logic                       wr_en,
  input  wire logic      [CAPTURE_AW-1:0] wr_addr,
  input  wire logic      [CAPTURE_AW-1:0] rd_addr,
  output lane_t                           rd_data       // valid one cycle after rd_addr
);

  lane_t mem [2**CAPTURE_AW];  // maps onto block ram
  lane_t sel_q;                // selected channel, one stage

  always_ff @(posedge clk_adc) begin
    sel_q <= chan_lanes[capture_sel];       // channel mux ahead of the ram
    if (wr_en) mem[wr_addr] <= sel_q;
    rd_data <= mem[rd_addr];                // read port
  end

endmodule

`default_nettype wire

// File: rtl/frame_align.sv
/*
  frame alignment
  hunts for the frame pattern with single bitslips, settling after each one
*/
`timescale 1ns/1ps
`default_nettype none

module frame_align
  import adc_in_pkg::*;
#(
  parameter int SETTLE_CYCLES = DEF_SETTLE_CYCLES
) (
  input  wire logic  clk_adc,
  input  wire logic  rst_adc_n,
  input  wire lane_t frame_lane,
  output logic       bitslip,   // one cycle pulse to the serdes
  output logic       locked     // frame lane matches the pattern
);

  localparam int CNT_W = $clog2(SETTLE_CYCLES + 1);

  typedef enum logic [1:0] {
    ST_CHECK,   // compare frame lane against pattern
    ST_SLIP,    // bitslip pulse is out
    ST_SETTLE   // let the serdes output settle
  } state_t;

  state_t           state;
  logic [CNT_W-1:0] settle_cnt;  // remaining settle cycles

  always_ff @(posedge clk_adc or negedge rst_adc_n) begin
    if (!rst_adc_n) begin
      state      <= ST_CHECK;
      settle_cnt <= '0;
      bitslip    <= 1'b0;
      locked     <= 1'b0;
    end else begin
      case (state)
        ST_CHECK: begin
          locked <= (frame_lane == FRAME_PATTERN);
          if (frame_lane != FRAME_PATTERN) begin  // wrong word boundary, slip one bit
            bitslip <= 1'b1;
            state   <= ST_SLIP;
          end
        end
        ST_SLIP: begin
          bitslip    <= 1'b0;
          settle_cnt <= CNT_W'(SETTLE_CYCLES - 1);
          state      <= ST_SETTLE;
        end
        default: begin                            // settle countdown
          if (settle_cnt == '0) state <= ST_CHECK;
          else settle_cnt <= settle_cnt - 1'b1;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: rtl/lane_reorder.sv
/*
  lane re-order
  un-interleaves the deserializer word into eight channels and the frame lane
*/
`timescale 1ns/1ps
`default_nettype none

module lane_reorder
  import adc_in_pkg::*;
(
  input  wire logic      clk_adc,
  input  wire logic      rst_adc_n,
  input  wire raw_word_t data_in,     // bit order as delivered by the serdes
  output lanes_t         chan_lanes,  // registered sample lanes
  output lane_t          frame_lane   // registered frame lane
);

  raw_word_t re_order;  // lane k occupies bits k*10 +: 10

  // serdes delivers bit j of every lane before bit j+1 of any lane
  for (genvar j = 0; j < LANE_BITS; j++) begin : g_bit
    for (genvar k = 0; k < LANES; k++) begin : g_lane
      assign re_order[k*LANE_BITS + j] = data_in[j*LANES + k];
    end
  end

  always_ff @(posedge clk_adc or negedge rst_adc_n) begin
    if (!rst_adc_n) begin
      chan_lanes <= '0;
      frame_lane <= '0;
    end else begin
      chan_lanes <= re_order[CHANNELS*LANE_BITS-1:0];                    // lanes 0..7
      frame_lane <= re_order[LANES*LANE_BITS-1 -: LANE_BITS];            // lane 8
    end
  end

endmodule

`default_nettype wire

// File: rtl/stream_out.sv
/*
  channel stream output
  sample fifo with credit flow control, packet beat counter and overflow flag
*/
`timescale 1ns/1ps
`default_nettype none

module stream_out
  import adc_in_pkg::*;
#(
  parameter int STREAM_DEPTH = DEF_STREAM_DEPTH,
  parameter int CREDIT_MAX   = DEF_CREDIT_MAX,
  parameter int PIXEL_SIZE   = DEF_PIXEL_SIZE
) (
  input  wire logic                               clk_adc,
  input  wire logic                               rst_adc_n,
  input  wire lanes_t                             chan_lanes,
  input  wire logic                               in_pixel,
  input  wire logic                               locked,
  input  wire logic                               credit_return,  // one credit per pulse
  output logic      [CHANNELS*SAMPLE_BITS-1:0]    out_data,
  output logic                                    out_valid,
  output logic                                    out_last,       // last beat of a packet
  output logic                                    overflow        // sticky, sample dropped
);

  localparam int PTR_W  = $clog2(STREAM_DEPTH);
  localparam int CR_W   = $clog2(CREDIT_MAX + 1);
  localparam int BEAT_W = $clog2(PIXEL_SIZE + 1);

  lanes_t              fifo_mem [STREAM_DEPTH];
  lanes_t              data_q;                    // beat payload
  logic [PTR_W-1:0]    wr_ptr, rd_ptr;
  logic [PTR_W:0]      count;                     // words held
  logic [CR_W-1:0]     credits;                   // beats we may still send
  logic [BEAT_W-1:0]   beat_cnt;                  // position within packet
  logic                push, pop, full;

  assign full = (count == (PTR_W+1)'(STREAM_DEPTH));
  assign push = in_pixel && locked && !full;     // full fifo drops the sample
  assign pop  = (count != '0) && (credits != '0);

  always_ff @(posedge clk_adc) begin
    if (push) fifo_mem[wr_ptr] <= chan_lanes;
    if (pop) data_q <= fifo_mem[rd_ptr];
  end

  always_ff @(posedge clk_adc or negedge rst_adc_n) begin
    if (!rst_adc_n) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      credits   <= CR_W'(CREDIT_MAX);
      beat_cnt  <= '0;
      out_valid <= 1'b0;
      out_last  <= 1'b0;
      overflow  <= 1'b0;
    end else begin
      if (push) wr_ptr <= (wr_ptr == PTR_W'(STREAM_DEPTH-1)) ? '0 : wr_ptr + 1'b1;
      if (pop) rd_ptr <= (rd_ptr == PTR_W'(STREAM_DEPTH-1)) ? '0 : rd_ptr + 1'b1;
      count   <= count + (PTR_W+1)'(push) - (PTR_W+1)'(pop);
      credits <= credits + CR_W'(credit_return) - CR_W'(pop);
      if (in_pixel && locked && full) overflow <= 1'b1;
      out_valid <= pop;                                          // beat goes out next cycle
      out_last  <= pop && (beat_cnt == BEAT_W'(PIXEL_SIZE-1));
      if (pop) beat_cnt <= (beat_cnt == BEAT_W'(PIXEL_SIZE-1)) ? '0 : beat_cnt + 1'b1;
    end
  end

  // each 10 bit lane widened to a 16 bit sample, high bits zero
  for (genvar n = 0; n < CHANNELS; n++) begin : g_ext
    assign out_data[n*SAMPLE_BITS +: SAMPLE_BITS] = sample_t'(data_q[n]);
  end

endmodule

`default_nettype wire

// File: test/tb_adc_input.sv
/*
  adc input front end testbench
  deserializer and credit source models around table-driven rows
*/
`timescale 1ns/1ps
`default_nettype none

module tb_adc_input
  import adc_in_pkg::*;
();

  localparam int AW = 5;                          // capture address width
  localparam int PIX = 12;                        // beats per packet
  localparam int SETTLE = 3;                      // settle cycles after a bitslip
  localparam int DEPTH = DEF_STREAM_DEPTH;
  localparam int CMAX = DEF_CREDIT_MAX;
  localparam int ROWS = 5;

  logic clk_adc = 1'b0;
  logic rst_adc_n = 1'b0;
  raw_word_t data_in = '0;
  logic bitslip, locked, capture_busy, out_valid, out_last, overflow;
  logic capture_start = 1'b0;
  chan_sel_t capture_sel = '0;
  logic [AW-1:0] rd_addr = '0;
  lane_t rd_data;
  logic in_pixel = 1'b0;
  logic credit_return = 1'b0;
  logic [CHANNELS*SAMPLE_BITS-1:0] out_data;

  // stimulus table
  string row_name [ROWS];
  int row_rot [ROWS];                             // initial frame rotation
  int row_sel [ROWS];                             // capture channel
  int row_hold [ROWS];                            // cycles credits are withheld
  int row_pix [ROWS];                             // in_pixel cycles
  int row_beats [ROWS];                           // beats expected back

  string cur_name = "reset";
  int errors = 0;
  int checks = 0;
  int seed = 88;
  int rot = 0;                                    // frame lane rotation in the serdes model
  int cnt7 = 0;                                   // free-running sample count
  int cycle = 0;
  int limit = 1000;
  int row_slips = 0;
  int last_slip = 0;
  int hold_left = 0;
  int owed = 0;                                   // beats not yet credited back
  int row_got = 0;
  int total_beats = 0;
  int prev [CHANNELS];
  bit prev_ok = 0;
  bit ovf_expect = 0;                             // sticky once a row overruns the fifo

  adc_input_top #(.CAPTURE_AW(AW), .PIXEL_SIZE(PIX), .SETTLE_CYCLES(SETTLE)) adc_input_top_i (
    .clk_adc, .rst_adc_n, .data_in, .bitslip, .locked, .capture_start, .capture_sel,
    .capture_busy, .rd_addr, .rd_data, .in_pixel, .credit_return, .out_data,
    .out_valid, .out_last, .overflow
  );

  always #10 clk_adc = ~clk_adc;

  task automatic check(input string what, input int expected, input int actual);
    checks++;
    if (expected != actual) begin
      errors++;
      $display("ERR %s %s: expected %0h actual %0h", cur_name, what, expected, actual);
    end
  endtask

  // bit j of lane k goes to data_in bit j*9+k
  function automatic raw_word_t interleave(input int frame_rot, input int count);
    raw_word_t d;
    logic [LANE_BITS-1:0] lane;
    logic [19:0] twice;
    d = '0;
    twice = {10'h3F8, 10'h3F8};
    for (int k = 0; k < LANES; k++) begin
      if (k == LANES - 1) lane = twice[19 - frame_rot -: 10];  // rotate left by frame_rot
      else lane = {k[2:0], count[6:0]};
      for (int j = 0; j < LANE_BITS; j++) d[j*LANES + k] = lane[j];
    end
    return d;
  endfunction

  task automatic step();
    @(posedge clk_adc);
    #2;
  endtask

  // serdes model and credit source driven after the edge
  always @(posedge clk_adc) begin
    #2;
    cnt7 = (cnt7 + 1) % 128;
    data_in <= interleave(rot, cnt7);
    credit_return <= 1'b0;
    if (hold_left > 0) hold_left--;
    else if (owed > 0 && ($random(seed) & 1)) begin
      credit_return <= 1'b1;
      owed--;
    end
  end

  always @(posedge clk_adc) begin
    cycle++;
    if (cycle > limit) begin
      $display("timeout: run exceeded %0d cycles", limit);
      $display("Done: errors found");
      $finish;
    end
  end

  // monitors sample at the falling edge
  always @(negedge clk_adc) begin
    if (rst_adc_n && bitslip) begin
      if (row_slips > 0) check("slip gap", SETTLE + 2, cycle - last_slip);
      row_slips++;
      last_slip = cycle;
      rot = (rot + 9) % 10;                       // one bit closer to the pattern
    end
    if (rst_adc_n && out_valid) begin
      check("out_last", ((total_beats + 1) % PIX) == 0, out_last);
      for (int n = 0; n < CHANNELS; n++) begin
        check("high bits", 0, out_data[n*16+10 +: 6]);
        check("channel", n, out_data[n*16+7 +: 3]);
        if (prev_ok) check("sample count", (prev[n] + 1) % 128, out_data[n*16 +: 7]);
        prev[n] = out_data[n*16 +: 7];
      end
      prev_ok = 1;
      total_beats++;
      row_got++;
      owed++;
      if (owed > CMAX) begin
        errors++;
        $display("%s: %0d beats outstanding, more than the credit limit", cur_name, owed);
      end
    end else if (rst_adc_n) begin
      check("out_last idle", 0, out_last);
    end
  end

  task automatic run_row(input int r);
    lane_t word;
    int first;
    cur_name = row_name[r];
    row_slips = 0;
    rot = row_rot[r];
    capture_sel = chan_sel_t'(row_sel[r]);
    if (row_rot[r] > 0) begin
      while (locked) step();
    end
    while (!locked) step();
    check("bitslips to lock", row_rot[r], row_slips);
    prev_ok = 0;
    row_got = 0;
    hold_left = row_hold[r];
    in_pixel = 1'b1;
    repeat (row_pix[r]) step();
    in_pixel = 1'b0;
    while (row_got < row_beats[r]) step();
    while (hold_left > 0 || owed > 0) step();
    repeat (6) step();
    check("beats", row_beats[r], row_got);
    if (row_hold[r] > DEPTH + CMAX && row_pix[r] > DEPTH + CMAX) ovf_expect = 1;
    check("overflow", ovf_expect, overflow);
    capture_start = 1'b1;
    step();
    capture_start = 1'b0;
    check("capture_busy", 1, capture_busy);
    while (capture_busy) step();
    for (int i = 0; i < 2**AW; i++) begin
      rd_addr = AW'(i);
      @(posedge clk_adc);
      @(negedge clk_adc);
      word = rd_data;
      check("capture channel", row_sel[r], word[9:7]);
      if (i > 0) check("capture count", (first + i) % 128, word[6:0]);
      else first = word[6:0];
      step();
    end
  endtask

  initial begin
    row_name = '{"align_r3", "align_r7", "no_slip", "overflow", "after_ovf"};
    row_rot = '{3, 7, 0, 1, 9};
    row_sel = '{2, 5, 0, 7, 3};
    row_hold = '{0, 6, 2, 30, 0};
    row_pix = '{10, 12, 8, 20, 12};
    row_beats = '{10, 12, 8, 12, 12};
    limit = 200;
    for (int r = 0; r < ROWS; r++)
      limit += row_rot[r] * (SETTLE + 2) + row_pix[r] + row_hold[r] + 3 * 2**AW + 80;
    rot = row_rot[0];
    repeat (16) step();
    check("bitslip in reset", 0, bitslip);
    check("locked in reset", 0, locked);
    check("busy in reset", 0, capture_busy);
    check("valid in reset", 0, out_valid);
    check("last in reset", 0, out_last);
    check("overflow in reset", 0, overflow);
    rst_adc_n = 1'b1;
    for (int r = 0; r < ROWS; r++) run_row(r);
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
rtl/adc_in_pkg.sv
rtl/lane_reorder.sv
rtl/frame_align.sv
rtl/capture_fsm.sv
rtl/capture_counter.sv
rtl/capture_mem.sv
rtl/stream_out.sv
rtl/adc_input_top.sv
test/tb_adc_input.sv
